// File: list.f
+incdir+src
src/mem_bus_pkg.sv
src/dmem_req_pkg.sv
src/dmem_ifs.sv
src/dmem_issue_queue.sv
src/dmem_load_tracker.sv
src/dmem_fill_return.sv
src/dcache_mem_ctrl.sv
tb/dcache_mem_ctrl_props.sv
tb/dcache_mem_ctrl_tb.sv

// File: tb/dcache_mem_ctrl_tb.sv
// random traffic on all three channels against an in-order memory model
// memory refuses about one command in four and stalls in bursts
`timescale 1ns/10ps
`default_nettype none
`include "dmem_config.svh"

module dcache_mem_ctrl_tb
    import mem_bus_pkg::*;
    import dmem_req_pkg::*;
();

    localparam int NUM_OPS = 400;

    typedef struct {
        req_kind_e                 kind;
        logic [`DMEM_ADDR_W-1:0]   addr;
        logic [63:0]               data;
        mem_size_e                 size;
        logic [`DMEM_LSQ_SIZE-1:0] grant;
        int                        epoch;
    } req_t;

    typedef struct {
        logic [`DMEM_ADDR_W-1:0]   addr;
        mem_size_e                 size;
        logic [`DMEM_LSQ_SIZE-1:0] grant;
        logic                      live;
    } read_t;

    typedef struct {
        mem_tag_t                tag;
        logic [`DMEM_ADDR_W-1:0] addr;
        int                      due;
    } ret_t;

    logic clock;
    logic reset;
    logic except;
    logic wb_valid, wb_ready, wr_valid, wr_ready, rd_valid, rd_ready;
    logic [`DMEM_ADDR_W-1:0]   wb_addr, wr_addr, rd_addr, dmem_addr;
    logic [63:0]               wb_data, wr_data, mem2proc_data, dmem_data, fill_data;
    mem_size_e                 wr_size, rd_size, dmem_size;
    logic [`DMEM_LSQ_SIZE-1:0] rd_grant, lsq_feedback;
    mem_tag_t                  mem2proc_response, mem2proc_tag;
    mem_command_e              dmem_command;
    logic                      fill_en;
    logic [4:0]                fill_idx;
    logic [7:0]                fill_tag;
    logic [31:0]               lsq_data;

    logic [31:0] lfsr = 32'h96e0_a24c;
    req_t        pending [$];
    read_t       tracked [$];
    ret_t        returns [$];
    int          cyc, made, cur_epoch, last_due, checks, errors;
    int          fills, cancelled, stores;
    logic        draining, done, wb_taken, wr_taken, rd_taken;
    mem_tag_t    next_tag;

    dcache_mem_ctrl dut (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // memory contents, fixed per address
    function automatic logic [63:0] mem_value(input logic [15:0] a);
        return {a ^ 16'hc3a5, a * 16'h2f1d, ~a, {a[7:0], a[15:8]} + 16'h1357};
    endfunction

    function automatic logic [31:0] load_value(input logic [15:0] a, input mem_size_e size);
        logic [31:0] word;
        word = 32'(mem_value(a) >> (8 * a[2:0]));
        case (size)
            BYTE:    return {24'h0, word[7:0]};
            HALF:    return {16'h0, word[15:0]};
            default: return word;
        endcase
    endfunction

    function automatic logic stale(input req_t r);
        return (r.kind == READ_MISS) && (r.epoch != cur_epoch);
    endfunction

    function automatic int live_pending();
        int n;
        n = 0;
        foreach (pending[i]) if (!stale(pending[i])) n++;
        return n;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    task automatic print_counts();
        $display("checks %0d, errors %0d, asserts %0d, stores %0d, fills %0d, cancelled %0d",
                 checks, errors, dut.props.failures, stores, fills, cancelled);
    endtask

    task automatic drive_requests();
        if (wb_taken || !wb_valid) begin
            wb_valid = !draining && (rand_bits(2) == 0);
            wb_addr  = rand_bits(16);
            wb_data  = rand_bits(64);
            if (wb_valid) made++;
        end
        if (wr_taken || !wr_valid) begin
            wr_valid = !draining && (rand_bits(2) == 0);
            wr_addr  = rand_bits(16);
            wr_data  = rand_bits(64);
            wr_size  = mem_size_e'(rand_bits(2));
            if (wr_valid) made++;
        end
        if (rd_taken || !rd_valid) begin
            rd_valid = !draining && rand_bits(1);
            rd_addr  = rand_bits(16);
            rd_size  = mem_size_e'(rand_bits(2));
            rd_grant = 16'h1 << rand_bits(4);
            if (rd_valid) made++;
        end
    endtask

    task automatic drive_memory();
        logic stall;
        // every 100 cycles a 20-cycle refusal burst fills the queue
        stall = !draining && ((cyc % 100) >= 80);
        if (reset || stall || rand_bits(2) == 0) begin
            mem2proc_response = '0;
        end else begin
            mem2proc_response = next_tag;
        end
        if (returns.size() > 0 && returns[0].due <= cyc) begin
            mem2proc_tag  = returns[0].tag;
            mem2proc_data = mem_value(returns[0].addr);
            void'(returns.pop_front());
        end else begin
            mem2proc_tag  = '0;
            mem2proc_data = '0;
        end
        // one epoch bit in the queue, so no older read may still wait there
        except = !reset && !draining && (mem2proc_tag == '0) &&
                 (live_pending() == pending.size()) && (rand_bits(5) == 0);
    endtask

    task automatic check_issue();
        req_t r;
        int   due;
        while (pending.size() > 0 && stale(pending[0])) void'(pending.pop_front());
        if (pending.size() == 0) begin
            report_error("memory accepted a command while no request was pending");
            return;
        end
        r = pending.pop_front();
        check_value("dmem_addr", dmem_addr, r.addr);
        if (r.kind == READ_MISS) begin
            check_value("dmem_command", dmem_command, BUS_LOAD);
            check_value("dmem_size", dmem_size, DOUBLE);
            tracked.push_back('{r.addr, r.size, r.grant, 1'b1});
            due = cyc + 2 + int'(rand_bits(2));
            if (due <= last_due) due = last_due + 1;
            last_due = due;
            returns.push_back('{mem2proc_response, r.addr, due});
        end else begin
            stores++;
            check_value("dmem_command", dmem_command, BUS_STORE);
            check_value("dmem_size", dmem_size, r.size);
            check_value("dmem_data", dmem_data, r.data);
        end
        next_tag = (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
    endtask

    task automatic check_return();
        read_t t;
        if (tracked.size() == 0) begin
            report_error("read data returned while no read was outstanding");
            return;
        end
        t = tracked.pop_front();
        if (t.live) begin
            fills++;
            check_value("fill_en", fill_en, 1'b1);
            check_value("fill_idx", fill_idx, t.addr[7:3]);
            check_value("fill_tag", fill_tag, t.addr[15:8]);
            check_value("fill_data", fill_data, mem_value(t.addr));
            check_value("lsq_feedback", lsq_feedback, t.grant);
            check_value("lsq_data", lsq_data, load_value(t.addr, t.size));
        end else begin
            cancelled++;
            check_value("fill_en", fill_en, 1'b0);
            check_value("lsq_feedback", lsq_feedback, '0);
        end
    endtask

    task automatic observe();
        if (cyc <= 9) begin
            check_value("wb_ready", wb_ready, 1'b0);
            check_value("wr_ready", wr_ready, 1'b0);
            check_value("rd_ready", rd_ready, 1'b0);
            check_value("dmem_command", dmem_command, BUS_NONE);
            check_value("lsq_data", lsq_data, '0);
        end
        if ((wr_ready && wb_valid) || (rd_ready && (wb_valid || wr_valid)) ||
            ($countones({wb_ready, wr_ready, rd_ready}) > 1)) begin
            report_error("arbiter granted a channel out of priority order");
        end
        wb_taken = !reset && wb_valid && wb_ready;
        wr_taken = !reset && wr_valid && wr_ready;
        rd_taken = !reset && rd_valid && rd_ready;
        if (wb_taken) pending.push_back('{WRITEBACK, wb_addr, wb_data, DOUBLE, '0, cur_epoch});
        if (wr_taken) pending.push_back('{WRITE_MISS, wr_addr, wr_data, wr_size, '0, cur_epoch});
        if (rd_taken) pending.push_back('{READ_MISS, rd_addr, '0, rd_size, rd_grant, cur_epoch});
        if (!reset && dmem_command != BUS_NONE && mem2proc_response != '0) check_issue();
        if (mem2proc_tag != '0) begin
            check_return();
        end else begin
            check_value("fill_en", fill_en, 1'b0);
            check_value("lsq_feedback", lsq_feedback, '0);
        end
        // a read issued in this cycle is cancelled too
        if (except) begin
            cur_epoch++;
            foreach (tracked[i]) tracked[i].live = 1'b0;
        end
    endtask

    initial begin
        reset = 1'b1;
        except = 1'b0;
        {wb_valid, wr_valid, rd_valid} = '0;
        {wb_addr, wr_addr, rd_addr} = '0;
        {wb_data, wr_data} = '0;
        wr_size = BYTE;
        rd_size = BYTE;
        rd_grant = '0;
        mem2proc_response = '0;
        mem2proc_data = '0;
        mem2proc_tag = '0;
        {wb_taken, wr_taken, rd_taken} = '0;
        {cyc, made, cur_epoch, last_due, checks, errors, fills, cancelled, stores} = '0;
        next_tag = 4'h1;
        done = 1'b0;
        while (!done) begin
            @(posedge clock);
            #2;
            reset = (cyc < 9);
            draining = (made >= NUM_OPS);
            drive_requests();
            drive_memory();
            @(negedge clock);
            observe();
            done = draining && (!wb_valid || wb_taken) && (!wr_valid || wr_taken) &&
                   (!rd_valid || rd_taken) && (live_pending() == 0) &&
                   (tracked.size() == 0) && (returns.size() == 0);
            cyc++;
        end
        print_counts();
        if (errors == 0 && dut.props.failures == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        repeat (NUM_OPS * 40) @(posedge clock);
        $display("ERROR %0t: watchdog expired before all requests drained", $time);
        print_counts();
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/dcache_mem_ctrl_props.sv
// bound to the controller top level, samples on the rising clock edge
`timescale 1ns/10ps
`default_nettype none
`include "dmem_config.svh"

module dcache_mem_ctrl_props
    import mem_bus_pkg::*;
(
    input logic                      clock,
    input logic                      reset,
    input mem_command_e              dmem_command,
    input logic [`DMEM_LSQ_SIZE-1:0] lsq_feedback,
    input logic                      fill_en,
    input mem_tag_t                  mem2proc_tag
);

    int failures = 0;

    // issue queue is empty after any reset edge
    command_idle_after_reset: assert property (
        @(posedge clock) reset |=> (dmem_command == BUS_NONE)
    ) else begin
        failures++;
        $error("memory command active in the cycle after reset");
    end

    feedback_one_hot: assert property (
        @(posedge clock) disable iff (reset) $onehot0(lsq_feedback)
    ) else begin
        failures++;
        $error("load-queue feedback has more than one bit set");
    end

    fill_needs_tag: assert property (
        @(posedge clock) disable iff (reset) fill_en |-> (mem2proc_tag != '0)
    ) else begin
        failures++;
        $error("cache fill without a returning memory tag");
    end

endmodule

bind dcache_mem_ctrl dcache_mem_ctrl_props props (
    .clock        (clock),
    .reset        (reset),
    .dmem_command (dmem_command),
    .lsq_feedback (lsq_feedback),
    .fill_en      (fill_en),
    .mem2proc_tag (mem2proc_tag)
);

`default_nettype wire

// File: src/dcache_mem_ctrl.sv
// memory-side controller of a write-back, no-write-allocate dcache
// memory must answer commands in the same cycle and return reads in order
`timescale 1ns/10ps
`default_nettype none
`include "dmem_config.svh"

module dcache_mem_ctrl
    import mem_bus_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      except,

    input  logic                      wb_valid,
    output logic                      wb_ready,
    input  logic [`DMEM_ADDR_W-1:0]   wb_addr,
    input  logic [63:0]               wb_data,

    input  logic                      wr_valid,
    output logic                      wr_ready,
    input  logic [`DMEM_ADDR_W-1:0]   wr_addr,
    input  logic [63:0]               wr_data,
    input  mem_size_e                 wr_size,

    input  logic                      rd_valid,
    output logic                      rd_ready,
    input  logic [`DMEM_ADDR_W-1:0]   rd_addr,
    input  mem_size_e                 rd_size,
    input  logic [`DMEM_LSQ_SIZE-1:0] rd_grant,

    input  mem_tag_t                  mem2proc_response,
    input  logic [63:0]               mem2proc_data,
    input  mem_tag_t                  mem2proc_tag,

    output mem_command_e              dmem_command,
    output logic [`DMEM_ADDR_W-1:0]   dmem_addr,
    output mem_size_e                 dmem_size,
    output logic [63:0]               dmem_data,

    output logic                      fill_en,
    output logic [4:0]                fill_idx,
    output logic [7:0]                fill_tag,
    output logic [63:0]               fill_data,
    output logic [`DMEM_LSQ_SIZE-1:0] lsq_feedback,
    output logic [31:0]               lsq_data
);

    load_push_if push_bus ();
    load_head_if head_bus ();

    dmem_issue_queue issue_queue (
        .clock        (clock),
        .reset        (reset),
        .except       (except),
        .wb_valid     (wb_valid),
        .wb_ready     (wb_ready),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .wr_valid     (wr_valid),
        .wr_ready     (wr_ready),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .wr_size      (wr_size),
        .rd_valid     (rd_valid),
        .rd_ready     (rd_ready),
        .rd_addr      (rd_addr),
        .rd_size      (rd_size),
        .rd_grant     (rd_grant),
        .mem_response (mem2proc_response),
        .dmem_command (dmem_command),
        .dmem_addr    (dmem_addr),
        .dmem_size    (dmem_size),
        .dmem_data    (dmem_data),
        .push         (push_bus.source)
    );

    dmem_load_tracker load_tracker (
        .clock  (clock),
        .reset  (reset),
        .except (except),
        .push   (push_bus.sink),
        .head   (head_bus.source)
    );

    dmem_fill_return fill_return (
        .head         (head_bus.sink),
        .mem_tag      (mem2proc_tag),
        .mem_data     (mem2proc_data),
        .fill_en      (fill_en),
        .fill_idx     (fill_idx),
        .fill_tag     (fill_tag),
        .fill_data    (fill_data),
        .lsq_feedback (lsq_feedback),
        .lsq_data     (lsq_data)
    );

endmodule

`default_nettype wire

// File: src/dmem_fill_return.sv
// combinational, fill and feedback only for live reads, no sign extension
`timescale 1ns/10ps
`default_nettype none
`include "dmem_config.svh"

module dmem_fill_return
    import mem_bus_pkg::*;
(
    load_head_if.sink                 head,
    input  mem_tag_t                  mem_tag,
    input  logic [63:0]               mem_data,
    output logic                      fill_en,
    output logic [4:0]                fill_idx,
    output logic [7:0]                fill_tag,
    output logic [63:0]               fill_data,
    output logic [`DMEM_LSQ_SIZE-1:0] lsq_feedback,
    output logic [31:0]               lsq_data
);

    logic        match;
    logic        hit;
    logic [63:0] shifted;
    logic [31:0] size_mask;

    assign match    = head.valid && (mem_tag == head.tag);
    assign hit      = match && head.live;
    assign head.pop = match;

    // byte offset within the double word
    assign shifted = mem_data >> {head.addr[2:0], 3'b000};

    always_comb begin
        case (head.size)
            BYTE:    size_mask = 32'h0000_00ff;
            HALF:    size_mask = 32'h0000_ffff;
            default: size_mask = 32'hffff_ffff;
        endcase
    end

    assign fill_en      = hit;
    assign fill_idx     = hit ? head.addr[7:3] : '0;
    assign fill_tag     = hit ? head.addr[15:8] : '0;
    assign fill_data    = hit ? mem_data : '0;
    assign lsq_feedback = hit ? head.grant : '0;
    assign lsq_data     = hit ? (shifted[31:0] & size_mask) : '0;

endmodule

`default_nettype wire

// File: src/dmem_load_tracker.sv
// reads accepted by memory, oldest first, memory must return tags in order
// cancelled reads stay queued until their data comes back
`timescale 1ns/10ps
`default_nettype none
`include "dmem_config.svh"

module dmem_load_tracker
    import mem_bus_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         except,
    load_push_if.sink    push,
    load_head_if.source  head
);

    localparam int DEPTH = `DMEM_TRACK_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    mem_tag_t                  tag_q   [DEPTH];
    logic [`DMEM_ADDR_W-1:0]   addr_q  [DEPTH];
    mem_size_e                 size_q  [DEPTH];
    logic [`DMEM_LSQ_SIZE-1:0] grant_q [DEPTH];
    logic [DEPTH-1:0]          live_q;
    logic [PTR_W-1:0]          head_ptr;
    logic [PTR_W-1:0]          tail_ptr;
    logic [CNT_W-1:0]          count;
    logic                      do_push;
    logic                      do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push.ready = (count != CNT_W'(DEPTH));
    assign do_push    = push.valid && push.ready;
    assign do_pop     = head.pop && head.valid;

    assign head.valid = (count != '0);
    assign head.tag   = tag_q[head_ptr];
    assign head.addr  = addr_q[head_ptr];
    assign head.size  = size_q[head_ptr];
    assign head.grant = grant_q[head_ptr];
    assign head.live  = live_q[head_ptr];

    always_ff @(posedge clock) begin
        if (do_push) begin
            tag_q[tail_ptr]   <= push.tag;
            addr_q[tail_ptr]  <= push.addr;
            size_q[tail_ptr]  <= push.size;
            grant_q[tail_ptr] <= push.grant;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
            live_q   <= '0;
        end else begin
            if (except) begin
                live_q <= '0;
            end
            // a read issued in the except cycle is cancelled as well
            if (do_push) begin
                live_q[tail_ptr] <= !except;
                tail_ptr         <= next_ptr(tail_ptr);
            end
            if (do_pop) begin
                head_ptr <= next_ptr(head_ptr);
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

endmodule

`default_nettype wire

// File: src/dmem_issue_queue.sv
// one request accepted per cycle, priority write-back, write miss, read miss
// reads accepted in an except cycle or earlier are dropped before issue
`timescale 1ns/10ps
`default_nettype none
`include "dmem_config.svh"

module dmem_issue_queue
    import mem_bus_pkg::*;
    import dmem_req_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      except,

    input  logic                      wb_valid,
    output logic                      wb_ready,
    input  logic [`DMEM_ADDR_W-1:0]   wb_addr,
    input  logic [63:0]               wb_data,

    input  logic                      wr_valid,
    output logic                      wr_ready,
    input  logic [`DMEM_ADDR_W-1:0]   wr_addr,
    input  logic [63:0]               wr_data,
    input  mem_size_e                 wr_size,

    input  logic                      rd_valid,
    output logic                      rd_ready,
    input  logic [`DMEM_ADDR_W-1:0]   rd_addr,
    input  mem_size_e                 rd_size,
    input  logic [`DMEM_LSQ_SIZE-1:0] rd_grant,

    input  mem_tag_t                  mem_response,
    output mem_command_e              dmem_command,
    output logic [`DMEM_ADDR_W-1:0]   dmem_addr,
    output mem_size_e                 dmem_size,
    output logic [63:0]               dmem_data,

    load_push_if.source               push
);

    localparam int DEPTH = `DMEM_ISSUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    dmem_entry_t      entries [DEPTH];
    dmem_entry_t      new_entry;
    dmem_entry_t      head_entry;
    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;
    logic [CNT_W-1:0] count;
    logic             epoch;
    logic             running;
    logic             can_accept;
    logic             accept;
    logic             head_valid;
    logic             head_is_read;
    logic             head_stale;
    logic             issue_done;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // ready only for the granted channel, from the first cycle after reset
    assign can_accept = running && (count != CNT_W'(DEPTH));
    assign wb_ready   = can_accept && wb_valid;
    assign wr_ready   = can_accept && wr_valid && !wb_valid;
    assign rd_ready   = can_accept && rd_valid && !wb_valid && !wr_valid;
    assign accept     = wb_ready || wr_ready || rd_ready;

    always_comb begin
        new_entry       = '0;
        new_entry.epoch = epoch;
        if (wb_ready) begin
            new_entry.kind = WRITEBACK;
            new_entry.addr = wb_addr;
            new_entry.data = wb_data;
            new_entry.size = DOUBLE;
        end else if (wr_ready) begin
            new_entry.kind = WRITE_MISS;
            new_entry.addr = wr_addr;
            new_entry.data = wr_data;
            new_entry.size = wr_size;
        end else begin
            new_entry.kind  = READ_MISS;
            new_entry.addr  = rd_addr;
            new_entry.size  = rd_size;
            new_entry.grant = rd_grant;
        end
    end

    assign head_entry   = entries[head_ptr];
    assign head_valid   = (count != '0);
    assign head_is_read = (head_entry.kind == READ_MISS);
    assign head_stale   = head_valid && head_is_read && (head_entry.epoch != epoch);

    // a read waits for room in the tracker so its push is never refused
    always_comb begin
        dmem_command = BUS_NONE;
        if (head_valid && !head_stale) begin
            if (!head_is_read) begin
                dmem_command = BUS_STORE;
            end else if (push.ready) begin
                dmem_command = BUS_LOAD;
            end
        end
    end

    assign dmem_addr = head_entry.addr;
    assign dmem_size = head_is_read ? DOUBLE : head_entry.size;
    assign dmem_data = head_entry.data;

    assign issue_done = (dmem_command != BUS_NONE) && (mem_response != '0);
    assign pop        = issue_done || head_stale;

    assign push.valid = issue_done && head_is_read;
    assign push.addr  = head_entry.addr;
    assign push.size  = head_entry.size;
    assign push.grant = head_entry.grant;
    assign push.tag   = mem_response;

    always_ff @(posedge clock) begin
        if (reset) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
            epoch    <= 1'b0;
            running  <= 1'b0;
        end else begin
            running <= 1'b1;
            if (except) begin
                epoch <= ~epoch;
            end
            if (accept) begin
                tail_ptr <= next_ptr(tail_ptr);
            end
            if (pop) begin
                head_ptr <= next_ptr(head_ptr);
            end
            count <= count + CNT_W'(accept) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            entries[tail_ptr] <= new_entry;
        end
    end

endmodule

`default_nettype wire

// File: src/dmem_ifs.sv
// links between issue queue, load tracker and fill-return stage
`timescale 1ns/10ps
`default_nettype none
`include "dmem_config.svh"

// read accepted by memory, handed to the tracker
interface load_push_if import mem_bus_pkg::*; ();
    logic                      valid;
    logic                      ready;
    logic [`DMEM_ADDR_W-1:0]   addr;
    mem_size_e                 size;
    logic [`DMEM_LSQ_SIZE-1:0] grant;
    mem_tag_t                  tag;

    modport source (output valid, addr, size, grant, tag, input ready);
    modport sink   (input valid, addr, size, grant, tag, output ready);
endinterface

// oldest outstanding read
interface load_head_if import mem_bus_pkg::*; ();
    logic                      valid;
    mem_tag_t                  tag;
    logic [`DMEM_ADDR_W-1:0]   addr;
    mem_size_e                 size;
    logic [`DMEM_LSQ_SIZE-1:0] grant;
    logic                      live;
    logic                      pop;

    modport source (output valid, tag, addr, size, grant, live, input pop);
    modport sink   (input valid, tag, addr, size, grant, live, output pop);
endinterface

`default_nettype wire

// File: src/dmem_req_pkg.sv
// request types of the controller, one queue entry per accepted request
`include "dmem_config.svh"
`default_nettype none

package dmem_req_pkg;

    import mem_bus_pkg::*;

    typedef enum logic [1:0] {
        WRITEBACK  = 2'h0,
        WRITE_MISS = 2'h1,
        READ_MISS  = 2'h2
    } req_kind_e;

    typedef struct packed {
        req_kind_e                 kind;
        logic [`DMEM_ADDR_W-1:0]   addr;
        logic [63:0]               data;
        mem_size_e                 size;
        logic [`DMEM_LSQ_SIZE-1:0] grant;
        logic                      epoch;
    } dmem_entry_t;

endpackage

`default_nettype wire

// File: src/mem_bus_pkg.sv
// types of the tagged memory bus
// tag 0 means not accepted on a response and no data on a return
`default_nettype none

package mem_bus_pkg;

    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } mem_command_e;

    typedef enum logic [1:0] {
        BYTE   = 2'h0,
        HALF   = 2'h1,
        WORD   = 2'h2,
        DOUBLE = 2'h3
    } mem_size_e;

    typedef logic [3:0] mem_tag_t;

endpackage

`default_nettype wire

// File: src/dmem_config.svh
// sizing for the dcache memory-side controller
// track depth must stay below 16, tags are 4 bits and tag 0 is reserved
`ifndef DMEM_CONFIG_SVH
`define DMEM_CONFIG_SVH

// byte address width
`define DMEM_ADDR_W       16

// one-hot load-queue grant width
`define DMEM_LSQ_SIZE     16

`define DMEM_ISSUE_DEPTH  8
`define DMEM_TRACK_DEPTH  8

`endif
